//--- sources.f
+incdir+include
hw/mxint_pkg.sv
hw/mxint_dot_product.sv
hw/mxint_accumulator.sv
hw/mxint_bias_align.sv
hw/mxint_cast.sv
hw/mxint_linear.sv
verification/mxint_linear_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = mxint_linear_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/mxint_linear_tb.sv
// Self-checking testbench for the MXINT linear top, directed and LFSR neurons against a reference model
`include "mxint_settings.svh"

module mxint_linear_tb;

  localparam int NUM_DIRECTED = 4;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_NEURONS  = NUM_DIRECTED + NUM_RANDOM;
  localparam int TIMEOUT      = 2000;
  localparam int DIR_EXP [NUM_DIRECTED] = '{-8, 0, 0, 7};
  localparam int DIR_BIAS [NUM_DIRECTED] = '{5, 1, -7, -128};

  logic                clk = 1'b0;
  logic                rst;
  mxint_pkg::block_t   data_in;
  mxint_pkg::exp_t     edata_in;
  logic                data_in_valid;
  logic                data_in_ready;
  mxint_pkg::block_t   weight_in;
  mxint_pkg::exp_t     eweight;
  logic                weight_valid;
  logic                weight_ready;
  mxint_pkg::man_t     bias_in;
  mxint_pkg::exp_t     ebias;
  logic                bias_valid;
  logic                bias_ready;
  mxint_pkg::out_man_t data_out;
  mxint_pkg::out_exp_t edata_out;
  logic                data_out_valid;
  logic                data_out_ready = 1'b1;

  // Stimulus per neuron, in send order
  mxint_pkg::block_t act_blk [NUM_NEURONS][`MX_IN_DEPTH];
  mxint_pkg::exp_t   act_exp [NUM_NEURONS][`MX_IN_DEPTH];
  mxint_pkg::block_t wgt_blk [NUM_NEURONS][`MX_IN_DEPTH];
  mxint_pkg::exp_t   wgt_exp [NUM_NEURONS][`MX_IN_DEPTH];
  mxint_pkg::man_t   bias_man [NUM_NEURONS];
  mxint_pkg::exp_t   bias_exp [NUM_NEURONS];

  int          exp_man_q[$];
  int          exp_e_q[$];
  int          out_count = 0;
  logic        stall_on = 1'b0;
  logic [31:0] lfsr_state = 32'hb188ff68;
  string       test_name = "reset";

  mxint_linear dut (.*);

  always #20 clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Range limits show up about half the time
  function automatic mxint_pkg::exp_t rand_exp();
    if (rand_bits(1) == 1) begin
      return (rand_bits(1) == 1) ? mxint_pkg::exp_t'(7) : mxint_pkg::exp_t'(-8);
    end
    return mxint_pkg::exp_t'(rand_bits(4));
  endfunction

  // Exact fixed-point sum, then the smallest shift that fits 16 signed bits
  function automatic void ref_result(input int n, output int man, output int e);
    longint total;
    longint dot;
    int     sh;
    total = longint'($signed(bias_man[n])) <<< (int'(bias_exp[n]) + `MX_FRAC);
    for (int b = 0; b < `MX_IN_DEPTH; b++) begin
      dot = 0;
      for (int i = 0; i < `MX_BLOCK; i++) begin
        dot += longint'($signed(act_blk[n][b][i])) * longint'($signed(wgt_blk[n][b][i]));
      end
      total += dot <<< (int'(act_exp[n][b]) + int'(wgt_exp[n][b]) + `MX_FRAC);
    end
    sh = 0;
    while ((total >>> sh) > 32767 || (total >>> sh) < -32768) begin
      sh++;
    end
    man = int'(total >>> sh);
    e   = sh - `MX_FRAC;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  // Four-state compare so an unknown output counts as wrong
  task automatic check_value(input string name, input logic signed [63:0] expected,
                             input logic signed [63:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("MISMATCH %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic queue_neuron(input int n);
    int man;
    int e;
    ref_result(n, man, e);
    exp_man_q.push_back(man);
    exp_e_q.push_back(e);
  endtask

  // Small known values, exponents fixed per neuron
  task automatic set_directed();
    int a;
    int w;
    for (int n = 0; n < NUM_DIRECTED; n++) begin
      for (int b = 0; b < `MX_IN_DEPTH; b++) begin
        for (int i = 0; i < `MX_BLOCK; i++) begin
          case (n)
            0: begin
              a = i + 1;
              w = b + 1;
            end
            1: begin
              a = i + 1;
              w = 3;
            end
            2: begin
              a = -(i + 1);
              w = 5;
            end
            default: begin
              a = -128;
              w = 127;
            end
          endcase
          act_blk[n][b][i] = mxint_pkg::man_t'(a);
          wgt_blk[n][b][i] = mxint_pkg::man_t'(w);
        end
        act_exp[n][b] = mxint_pkg::exp_t'(DIR_EXP[n]);
        wgt_exp[n][b] = mxint_pkg::exp_t'(DIR_EXP[n]);
      end
      bias_man[n] = mxint_pkg::man_t'(DIR_BIAS[n]);
      bias_exp[n] = mxint_pkg::exp_t'(DIR_EXP[n]);
    end
  endtask

  task automatic set_random(input int n);
    for (int b = 0; b < `MX_IN_DEPTH; b++) begin
      for (int i = 0; i < `MX_BLOCK; i++) begin
        act_blk[n][b][i] = mxint_pkg::man_t'(rand_bits(8));
        wgt_blk[n][b][i] = mxint_pkg::man_t'(rand_bits(8));
      end
      act_exp[n][b] = rand_exp();
      wgt_exp[n][b] = rand_exp();
    end
    bias_man[n] = mxint_pkg::man_t'(rand_bits(8));
    bias_exp[n] = rand_exp();
  endtask

  // Stream 0 is activations, 1 weights, 2 bias
  task automatic present(input int which, input int n, input int b, input logic valid);
    case (which)
      0: begin
        data_in       <= act_blk[n][b];
        edata_in      <= act_exp[n][b];
        data_in_valid <= valid;
      end
      1: begin
        weight_in    <= wgt_blk[n][b];
        eweight      <= wgt_exp[n][b];
        weight_valid <= valid;
      end
      default: begin
        bias_in    <= bias_man[n];
        ebias      <= bias_exp[n];
        bias_valid <= valid;
      end
    endcase
  endtask

  function automatic logic stream_ready(input int which);
    case (which)
      0: return data_in_ready;
      1: return weight_ready;
      default: return bias_ready;
    endcase
  endfunction

  // Ready is sampled at the falling edge, the transfer lands on the next rising edge
  task automatic send_stream(input int which, input int first, input int last, input int max_gap);
    int   items;
    int   gap;
    int   waited;
    logic taken;
    items = (which == 2) ? 1 : `MX_IN_DEPTH;
    for (int n = first; n < last; n++) begin
      for (int b = 0; b < items; b++) begin
        gap = (max_gap > 0) ? int'(rand_bits(3)) % (max_gap + 1) : 0;
        if (gap > 0) begin
          present(which, n, b, 1'b0);
          repeat (gap) @(posedge clk);
        end
        present(which, n, b, 1'b1);
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
          @(negedge clk);
          taken = stream_ready(which);
          @(posedge clk);
          waited++;
          if (waited > TIMEOUT) begin
            abort_run($sformatf("Input stream %0d was never accepted for neuron %0d", which, n));
          end
        end
      end
    end
    present(which, last - 1, 0, 1'b0);
  endtask

  task automatic wait_outputs(input int count);
    int waited;
    waited = 0;
    while (out_count < count) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run($sformatf("Only %0d of %0d results came out in time", out_count, count));
      end
    end
  endtask

  // Output back-pressure
  always @(posedge clk) begin
    data_out_ready <= stall_on ? (rand_bits(2) != 0) : 1'b1;
  end

  // Scoreboard, one comparison per output transfer
  always @(negedge clk) begin
    if (!rst && data_out_valid && data_out_ready) begin
      if (exp_man_q.size() == 0) begin
        abort_run("A result came out with no neuron pending");
      end else begin
        check_value($sformatf("%s neuron %0d mantissa", test_name, out_count),
                    64'(exp_man_q.pop_front()), 64'(data_out));
        check_value($sformatf("%s neuron %0d exponent", test_name, out_count),
                    64'(exp_e_q.pop_front()), 64'(edata_out));
        out_count++;
      end
    end
  end

  initial begin
    rst           <= 1'b1;
    data_in       <= '0;
    edata_in      <= '0;
    data_in_valid <= 1'b0;
    weight_in     <= '0;
    eweight       <= '0;
    weight_valid  <= 1'b0;
    bias_in       <= '0;
    ebias         <= '0;
    bias_valid    <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    test_name = "idle after reset";
    repeat (4) begin
      @(negedge clk);
      check_value(test_name, 64'sd0, 64'(data_out_valid));
    end

    test_name = "directed";
    set_directed();
    for (int n = 0; n < NUM_DIRECTED; n++) begin
      queue_neuron(n);
    end
    @(posedge clk);
    fork
      send_stream(0, 0, NUM_DIRECTED, 0);
      send_stream(1, 0, NUM_DIRECTED, 0);
      send_stream(2, 0, NUM_DIRECTED, 0);
    join
    wait_outputs(NUM_DIRECTED);

    // Bias gaps are longer so it lands before or after its products
    test_name = "random";
    for (int n = NUM_DIRECTED; n < NUM_NEURONS; n++) begin
      set_random(n);
      queue_neuron(n);
    end
    stall_on <= 1'b1;
    @(posedge clk);
    fork
      send_stream(0, NUM_DIRECTED, NUM_NEURONS, 3);
      send_stream(1, NUM_DIRECTED, NUM_NEURONS, 3);
      send_stream(2, NUM_DIRECTED, NUM_NEURONS, 7);
    join
    wait_outputs(NUM_NEURONS);
    stall_on <= 1'b0;
    repeat (8) @(posedge clk);

    if (out_count == NUM_NEURONS && exp_man_q.size() == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_run($sformatf("Got %0d results for %0d neurons", out_count, NUM_NEURONS));
    end
  end

endmodule

//--- hw/mxint_linear.sv
// Top level of the MXINT linear datapath, one output neuron per dot product and bias pair
module mxint_linear (
  input  logic                clk,
  input  logic                rst,

  // Activation blocks
  input  mxint_pkg::block_t   data_in,
  input  mxint_pkg::exp_t     edata_in,
  input  logic                data_in_valid,
  output logic                data_in_ready,

  // Weight blocks
  input  mxint_pkg::block_t   weight_in,
  input  mxint_pkg::exp_t     eweight,
  input  logic                weight_valid,
  output logic                weight_ready,

  // One bias per neuron
  input  mxint_pkg::man_t     bias_in,
  input  mxint_pkg::exp_t     ebias,
  input  logic                bias_valid,
  output logic                bias_ready,

  // Normalized result
  output mxint_pkg::out_man_t data_out,
  output mxint_pkg::out_exp_t edata_out,
  output logic                data_out_valid,
  input  logic                data_out_ready
);

  mxint_pkg::dp_man_t dp_man;
  mxint_pkg::dp_exp_t dp_exp;
  logic               dp_valid;
  logic               dp_ready;

  mxint_pkg::fix_t    acc_fix;
  logic               acc_valid;
  logic               acc_ready;

  mxint_pkg::fix_t    bias_fix;
  logic               bias_fix_valid;
  logic               bias_fix_ready;

  // Product path
  mxint_dot_product u_dot_product (
    .clk           (clk),
    .rst           (rst),
    .data_in       (data_in),
    .edata_in      (edata_in),
    .data_in_valid (data_in_valid),
    .data_in_ready (data_in_ready),
    .weight_in     (weight_in),
    .eweight       (eweight),
    .weight_valid  (weight_valid),
    .weight_ready  (weight_ready),
    .dp_man        (dp_man),
    .dp_exp        (dp_exp),
    .dp_valid      (dp_valid),
    .dp_ready      (dp_ready)
  );

  mxint_accumulator u_accumulator (
    .clk       (clk),
    .rst       (rst),
    .dp_man    (dp_man),
    .dp_exp    (dp_exp),
    .dp_valid  (dp_valid),
    .dp_ready  (dp_ready),
    .acc_fix   (acc_fix),
    .acc_valid (acc_valid),
    .acc_ready (acc_ready)
  );

  // Bias path runs alongside
  mxint_bias_align u_bias_align (
    .clk            (clk),
    .rst            (rst),
    .bias_in        (bias_in),
    .ebias          (ebias),
    .bias_valid     (bias_valid),
    .bias_ready     (bias_ready),
    .bias_fix       (bias_fix),
    .bias_fix_valid (bias_fix_valid),
    .bias_fix_ready (bias_fix_ready)
  );

  mxint_cast u_cast (
    .clk            (clk),
    .rst            (rst),
    .acc_fix        (acc_fix),
    .acc_valid      (acc_valid),
    .acc_ready      (acc_ready),
    .bias_fix       (bias_fix),
    .bias_fix_valid (bias_fix_valid),
    .bias_fix_ready (bias_fix_ready),
    .data_out       (data_out),
    .edata_out      (edata_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

endmodule

//--- hw/mxint_cast.sv
// Adds the accumulated neuron and its bias, then normalizes the sum to the output MXINT format
`include "mxint_settings.svh"

module mxint_cast (
  input  logic                clk,
  input  logic                rst,
  input  mxint_pkg::fix_t     acc_fix,
  input  logic                acc_valid,
  output logic                acc_ready,
  input  mxint_pkg::fix_t     bias_fix,
  input  logic                bias_fix_valid,
  output logic                bias_fix_ready,
  output mxint_pkg::out_man_t data_out,
  output mxint_pkg::out_exp_t edata_out,
  output logic                data_out_valid,
  input  logic                data_out_ready
);

  // Largest right shift ever needed to fit the output mantissa
  localparam int MAX_SHIFT = `MX_ACC_W - `MX_OUT_MAN_W;
  localparam int SHIFT_W   = $clog2(MAX_SHIFT + 1);

  logic               slot_free;
  logic               take_in;
  logic [SHIFT_W-1:0] norm_shift;
  mxint_pkg::fix_t    total;
  mxint_pkg::fix_t    shifted;

  assign slot_free = !data_out_valid || data_out_ready;

  // Neuron and bias are consumed on the same edge
  assign acc_ready      = slot_free && bias_fix_valid;
  assign bias_fix_ready = slot_free && acc_valid;
  assign take_in        = acc_valid && bias_fix_valid && slot_free;

  // Width bound guarantees no overflow here
  assign total = acc_fix + bias_fix;

  // Smallest shift whose upper bits are pure sign extension
  always_comb begin
    mxint_pkg::fix_t upper;
    norm_shift = SHIFT_W'(MAX_SHIFT);
    for (int i = MAX_SHIFT - 1; i >= 0; i--) begin
      upper = total >>> (i + `MX_OUT_MAN_W - 1);
      if (upper == '0 || upper == mxint_pkg::fix_t'(-1)) begin
        norm_shift = SHIFT_W'(i);
      end
    end
  end

  // Arithmetic shift rounds toward minus infinity
  assign shifted = total >>> norm_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out_valid <= 1'b0;
    end else if (take_in) begin
      data_out_valid <= 1'b1;
    end else if (data_out_ready) begin
      data_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take_in) begin
      data_out  <= mxint_pkg::out_man_t'(shifted);
      edata_out <= mxint_pkg::out_exp_t'(int'(norm_shift) - `MX_FRAC);
    end
  end

endmodule

//--- hw/mxint_bias_align.sv
// Converts an incoming MXINT bias to the shared fixed point and holds it in a one-entry register
`include "mxint_settings.svh"

module mxint_bias_align (
  input  logic            clk,
  input  logic            rst,
  input  mxint_pkg::man_t bias_in,
  input  mxint_pkg::exp_t ebias,
  input  logic            bias_valid,
  output logic            bias_ready,
  output mxint_pkg::fix_t bias_fix,
  output logic            bias_fix_valid,
  input  logic            bias_fix_ready
);

  localparam int SHIFT_W = $clog2(`MX_ACC_W);

  logic [SHIFT_W-1:0] bias_shift;
  logic               take_bias;
  mxint_pkg::fix_t    bias_aligned;

  // Register free now or freed by the cast this cycle
  assign bias_ready = !bias_fix_valid || bias_fix_ready;
  assign take_bias  = bias_valid && bias_ready;

  // Same rule as the products, so the cast adds like to like
  assign bias_shift   = SHIFT_W'(int'(ebias) + `MX_FRAC);
  assign bias_aligned = mxint_pkg::fix_t'(bias_in) <<< bias_shift;

  always_ff @(posedge clk) begin
    if (rst) begin
      bias_fix_valid <= 1'b0;
    end else if (take_bias) begin
      bias_fix_valid <= 1'b1;
    end else if (bias_fix_ready) begin
      bias_fix_valid <= 1'b0;
    end
  end

  // Bias may sit here while its neuron's products are still arriving
  always_ff @(posedge clk) begin
    if (take_bias) begin
      bias_fix <= bias_aligned;
    end
  end

endmodule

//--- hw/mxint_accumulator.sv
// Aligns each block dot product to fixed point and sums MX_IN_DEPTH of them per output neuron
`include "mxint_settings.svh"

module mxint_accumulator (
  input  logic               clk,
  input  logic               rst,
  input  mxint_pkg::dp_man_t dp_man,
  input  mxint_pkg::dp_exp_t dp_exp,
  input  logic               dp_valid,
  output logic               dp_ready,
  output mxint_pkg::fix_t    acc_fix,
  output logic               acc_valid,
  input  logic               acc_ready
);

  localparam int CNT_W   = (`MX_IN_DEPTH > 1) ? $clog2(`MX_IN_DEPTH) : 1;
  localparam int SHIFT_W = $clog2(`MX_ACC_W);

  logic [CNT_W-1:0]   count;
  logic [SHIFT_W-1:0] dp_shift;
  logic               take_dp;
  logic               last_dp;
  mxint_pkg::fix_t    dp_fix;
  mxint_pkg::fix_t    run_sum;
  mxint_pkg::fix_t    sum_next;

  // Hold off products while a finished neuron waits downstream
  assign dp_ready = !acc_valid || acc_ready;
  assign take_dp  = dp_valid && dp_ready;
  assign last_dp  = count == CNT_W'(`MX_IN_DEPTH - 1);

  // Exponent range keeps this shift non-negative
  assign dp_shift = SHIFT_W'(int'(dp_exp) + `MX_FRAC);
  assign dp_fix   = mxint_pkg::fix_t'(dp_man) <<< dp_shift;
  assign sum_next = run_sum + dp_fix;

  always_ff @(posedge clk) begin
    if (rst) begin
      count     <= '0;
      run_sum   <= '0;
      acc_valid <= 1'b0;
    end else begin
      if (acc_valid && acc_ready) begin
        acc_valid <= 1'b0;
      end
      if (take_dp) begin
        if (last_dp) begin
          // Neuron complete, start the next from zero
          count     <= '0;
          run_sum   <= '0;
          acc_valid <= 1'b1;
        end else begin
          count   <= count + 1'b1;
          run_sum <= sum_next;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take_dp && last_dp) begin
      acc_fix <= sum_next;
    end
  end

endmodule

//--- hw/mxint_dot_product.sv
// Joins one activation block and one weight block and registers their integer dot product
`include "mxint_settings.svh"

module mxint_dot_product (
  input  logic               clk,
  input  logic               rst,
  input  mxint_pkg::block_t  data_in,
  input  mxint_pkg::exp_t    edata_in,
  input  logic               data_in_valid,
  output logic               data_in_ready,
  input  mxint_pkg::block_t  weight_in,
  input  mxint_pkg::exp_t    eweight,
  input  logic               weight_valid,
  output logic               weight_ready,
  output mxint_pkg::dp_man_t dp_man,
  output mxint_pkg::dp_exp_t dp_exp,
  output logic               dp_valid,
  input  logic               dp_ready
);

  logic               slot_free;
  logic               take_in;
  mxint_pkg::dp_man_t prod_sum;
  mxint_pkg::dp_exp_t exp_sum;

  // Output register empty, or emptied this cycle
  assign slot_free = !dp_valid || dp_ready;

  // Both streams move together
  assign data_in_ready = slot_free && weight_valid;
  assign weight_ready  = slot_free && data_in_valid;
  assign take_in       = data_in_valid && weight_valid && slot_free;

  // Signed multiply-add across the block, widened before the multiply
  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < `MX_BLOCK; i++) begin
      prod_sum = prod_sum + mxint_pkg::dp_man_t'($signed(data_in[i]))
                          * mxint_pkg::dp_man_t'($signed(weight_in[i]));
    end
  end

  assign exp_sum = mxint_pkg::dp_exp_t'(edata_in) + mxint_pkg::dp_exp_t'(eweight);

  always_ff @(posedge clk) begin
    if (rst) begin
      dp_valid <= 1'b0;
    end else if (take_in) begin
      dp_valid <= 1'b1;
    end else if (dp_ready) begin
      dp_valid <= 1'b0;
    end
  end

  // Payload only changes on an accepted pair
  always_ff @(posedge clk) begin
    if (take_in) begin
      dp_man <= prod_sum;
      dp_exp <= exp_sum;
    end
  end

endmodule

//--- hw/mxint_pkg.sv
// Shared data types for the MXINT linear datapath, referenced by scoped names from every module
`include "mxint_settings.svh"

package mxint_pkg;

  // One input element and the shared block exponent
  typedef logic signed [`MX_MAN_W-1:0] man_t;
  typedef logic signed [`MX_EXP_W-1:0] exp_t;

  // A block of mantissas sharing one exponent
  typedef man_t [`MX_BLOCK-1:0] block_t;

  // Dot product of two blocks, full precision
  typedef logic signed [2*`MX_MAN_W+$clog2(`MX_BLOCK)-1:0] dp_man_t;
  typedef logic signed [`MX_EXP_W:0] dp_exp_t;

  // Internal fixed point, LSB weighs 2^-MX_FRAC
  typedef logic signed [`MX_ACC_W-1:0] fix_t;

  // Final cast result
  typedef logic signed [`MX_OUT_MAN_W-1:0] out_man_t;
  typedef logic signed [`MX_OUT_EXP_W-1:0] out_exp_t;

endpackage

//--- include/mxint_settings.svh
// Widths, block size and depth for the MXINT linear datapath, included by the package and benches
`ifndef MXINT_SETTINGS_SVH
`define MXINT_SETTINGS_SVH

// Input MXINT block format
`define MX_MAN_W 8
`define MX_EXP_W 4
`define MX_BLOCK 4

// Blocks summed into one output neuron
`define MX_IN_DEPTH 2

// Fixed point: exponent e becomes a left shift of e + MX_FRAC
`define MX_FRAC 16

// Wide enough for four blocks at the largest shift plus the bias
`define MX_ACC_W 52

// Output MXINT format
`define MX_OUT_MAN_W 16
`define MX_OUT_EXP_W 6

`endif
